// ==== verilog/test_proto_pkg.sv ====
package test_proto_pkg;

    // ====================
    // Link byte fields
    // ====================
    typedef logic [7:0] byte_t;
    typedef logic [1:0] cmd_t;
    typedef logic [5:0] len_t;

    // Header command, top two bits of a header byte
    localparam cmd_t CMD_TEST_START   = 2'd0;
    localparam cmd_t CMD_TEST_DATA    = 2'd1;
    localparam cmd_t CMD_TEST_STOP    = 2'd2;
    // Only ever sent back by the controller
    localparam cmd_t CMD_TEST_STOPPED = 2'd3;

    // ====================
    // Test selection
    // ====================
    typedef logic [7:0] test_num_t;

    localparam test_num_t TEST_RECEIVE      = 8'd1;
    localparam test_num_t TEST_SEND         = 8'd2;
    localparam test_num_t TEST_RECEIVE_SEND = 8'd3;

    // Error codes carried by the stop reply
    typedef logic [7:0] err_code_t;

    localparam err_code_t ERR_NONE                  = 8'd0;
    localparam err_code_t ERR_INVALID_CMD           = 8'd1;
    localparam err_code_t ERR_INVALID_START_PAYLOAD = 8'd2;
    localparam err_code_t ERR_INVALID_STOP_PAYLOAD  = 8'd3;
    localparam err_code_t ERR_INVALID_TEST_NUM      = 8'd4;
    localparam err_code_t ERR_INVALID_TEST_DATA     = 8'd5;

endpackage

// ==== verilog/test_ctrl_pkg.sv ====
package test_ctrl_pkg;

    // Control FSM states
    typedef enum logic [2:0] {
        ST_READ,
        ST_ECHO,
        ST_SEND,
        ST_REPORT,
        ST_HALT
    } ctrl_state_t;

    // Position in the incoming byte stream
    typedef enum logic {
        PS_HEADER,
        PS_PAYLOAD
    } parse_state_t;

    typedef logic [7:0] pkt_count_t;

endpackage

// ==== verilog/packet_parser.sv ====
module packet_parser (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  take_i,
    input  test_proto_pkg::byte_t byte_i,
    output logic                  is_header_o,
    output test_proto_pkg::cmd_t  cmd_o,
    output test_proto_pkg::len_t  len_o
);
    import test_proto_pkg::*;
    import test_ctrl_pkg::*;

    parse_state_t state;
    len_t         remain;
    cmd_t         last_cmd;

    assign is_header_o = (state == PS_HEADER);
    assign len_o       = byte_i[5:0];
    // Payload bytes inherit the command of their header
    assign cmd_o       = is_header_o ? byte_i[7:6] : last_cmd;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state    <= PS_HEADER;
            remain   <= '0;
            last_cmd <= CMD_TEST_START;
        end else if (take_i) begin
            if (state == PS_HEADER) begin
                last_cmd <= byte_i[7:6];
                remain   <= byte_i[5:0];
                // Empty packets stay in header mode
                if (byte_i[5:0] != '0) begin
                    state <= PS_PAYLOAD;
                end
            end else begin
                remain <= remain - 1'b1;
                if (remain == len_t'(1)) begin
                    state <= PS_HEADER;
                end
            end
        end
    end

endmodule

// ==== verilog/pattern_gen.sv ====
module pattern_gen #(
    parameter int unsigned PACKET_COUNT   = 1,
    parameter int unsigned PACKET_PAYLOAD = 63
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  clear_i,
    input  logic                  advance_i,
    input  logic                  send_start_i,
    input  logic                  pat_take_i,
    output test_proto_pkg::byte_t expected_o,
    output test_proto_pkg::byte_t pat_byte_o,
    output logic                  pat_last_o
);
    import test_proto_pkg::*;
    import test_ctrl_pkg::*;

    localparam len_t       PAYLOAD_LEN = len_t'(PACKET_PAYLOAD);
    localparam pkt_count_t NUM_PACKETS = pkt_count_t'(PACKET_COUNT);

    byte_t      expected;
    pkt_count_t packets_left;
    len_t       bytes_left;
    logic       at_header;
    logic       payload_take;

    assign payload_take = pat_take_i && !at_header;

    assign expected_o = expected;
    assign pat_byte_o = at_header ? {CMD_TEST_DATA, PAYLOAD_LEN} : expected;
    assign pat_last_o = !at_header && (bytes_left == len_t'(1))
                        && (packets_left == pkt_count_t'(1));

    // Expected byte, shared by the checker and the generator
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            expected <= '0;
        end else if (clear_i) begin
            expected <= '0;
        end else if (advance_i || payload_take) begin
            expected <= expected + 1'b1;
        end
    end

    // ====================
    // Send test framing
    // ====================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            packets_left <= '0;
            bytes_left   <= '0;
            at_header    <= 1'b1;
        end else if (send_start_i) begin
            packets_left <= NUM_PACKETS;
            bytes_left   <= PAYLOAD_LEN;
            at_header    <= 1'b1;
        end else if (pat_take_i) begin
            if (at_header) begin
                at_header <= 1'b0;
            end else if (bytes_left == len_t'(1)) begin
                // Packet done, next byte is a fresh header
                bytes_left   <= PAYLOAD_LEN;
                packets_left <= packets_left - 1'b1;
                at_header    <= 1'b1;
            end else begin
                bytes_left <= bytes_left - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/reply_writer.sv ====
module reply_writer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  load_i,
    input  test_proto_pkg::cmd_t  load_cmd_i,
    input  test_proto_pkg::len_t  load_len_i,
    input  test_proto_pkg::byte_t load_b1_i,
    input  test_proto_pkg::byte_t load_b2_i,
    input  test_proto_pkg::byte_t load_b3_i,
    input  logic                  stream_i,
    input  test_proto_pkg::byte_t pat_byte_i,
    input  logic                  wr_full_i,
    input  logic                  wr_afull_i,
    output logic                  busy_o,
    output logic                  pat_take_o,
    output logic                  wr_en_o,
    output test_proto_pkg::byte_t wr_data_o
);
    import test_proto_pkg::*;

    byte_t      reply_buf [4];
    logic [1:0] rd_idx;
    logic [1:0] last_idx;
    logic       busy;
    logic       space;
    logic       drain;

    // Both flags must be clear for a write
    assign space      = !wr_full_i && !wr_afull_i;
    assign drain      = busy && space;
    // Pattern bytes flow only while no reply is held
    assign pat_take_o = !busy && stream_i && space;
    assign busy_o     = busy;

    // Header plus up to three reply bytes
    always_ff @(posedge clk) begin
        if (load_i) begin
            reply_buf[0] <= {load_cmd_i, load_len_i};
            reply_buf[1] <= load_b1_i;
            reply_buf[2] <= load_b2_i;
            reply_buf[3] <= load_b3_i;
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            wr_data_o <= reply_buf[rd_idx];
        end else if (pat_take_o) begin
            wr_data_o <= pat_byte_i;
        end
    end

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            wr_en_o  <= 1'b0;
            busy     <= 1'b0;
            rd_idx   <= '0;
            last_idx <= '0;
        end else begin
            wr_en_o <= drain || pat_take_o;
            if (drain) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == last_idx) begin
                    busy <= 1'b0;
                end
            end
            // Length counts the bytes after the header
            if (load_i) begin
                busy     <= 1'b1;
                rd_idx   <= '0;
                last_idx <= load_len_i[1:0];
            end
        end
    end

endmodule

// ==== verilog/test_ctrl_fsm.sv ====
module test_ctrl_fsm (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  rd_empty_i,
    input  test_proto_pkg::byte_t rd_data_i,
    input  logic                  is_header_i,
    input  test_proto_pkg::cmd_t  cmd_i,
    input  test_proto_pkg::len_t  len_i,
    input  test_proto_pkg::byte_t expected_i,
    input  logic                  pat_last_i,
    input  logic                  pat_take_i,
    input  logic                  busy_i,
    output logic                  rd_en_o,
    output logic                  take_o,
    output logic                  clear_o,
    output logic                  advance_o,
    output logic                  send_start_o,
    output logic                  stream_o,
    output logic                  load_o,
    output test_proto_pkg::cmd_t  load_cmd_o,
    output test_proto_pkg::len_t  load_len_o,
    output test_proto_pkg::byte_t load_b1_o,
    output test_proto_pkg::byte_t load_b2_o,
    output test_proto_pkg::byte_t load_b3_o,
    output logic                  test_ok_o,
    output logic                  test_fail_o
);
    import test_proto_pkg::*;
    import test_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_d;
    test_num_t   test_num;
    err_code_t   err_code;
    err_code_t   rep_err;
    len_t        rep_len;
    logic        report;
    logic        start_hdr;
    logic        start_pld;

    assign rd_en_o   = (state == ST_READ);
    assign take_o    = rd_en_o && !rd_empty_i;
    assign stream_o  = (state == ST_SEND);
    assign start_hdr = take_o && is_header_i && (cmd_i == CMD_TEST_START);
    assign start_pld = take_o && !is_header_i && (cmd_i == CMD_TEST_START);

    // ====================
    // Command decode
    // ====================
    always_comb begin
        state_d      = state;
        clear_o      = 1'b0;
        advance_o    = 1'b0;
        send_start_o = 1'b0;
        load_o       = 1'b0;
        load_cmd_o   = CMD_TEST_STOPPED;
        load_len_o   = len_t'(1);
        load_b1_o    = ERR_NONE;
        // Received byte or test number, then expected byte
        load_b2_o    = rd_data_i;
        load_b3_o    = expected_i;
        report       = 1'b0;
        rep_err      = ERR_NONE;
        rep_len      = len_t'(1);

        case (state)
            ST_READ: begin
                if (take_o && is_header_i) begin
                    case (cmd_i)
                        CMD_TEST_START: begin
                            if (len_i == len_t'(1)) begin
                                clear_o = 1'b1;
                            end else begin
                                report  = 1'b1;
                                rep_err = ERR_INVALID_START_PAYLOAD;
                            end
                        end
                        CMD_TEST_DATA: begin
                            // Payload is checked byte by byte
                        end
                        CMD_TEST_STOP: begin
                            report  = 1'b1;
                            rep_err = (len_i == '0) ? ERR_NONE : ERR_INVALID_STOP_PAYLOAD;
                        end
                        default: begin
                            report  = 1'b1;
                            rep_err = ERR_INVALID_CMD;
                        end
                    endcase
                end else if (take_o && cmd_i == CMD_TEST_START) begin
                    case (rd_data_i)
                        TEST_RECEIVE, TEST_RECEIVE_SEND: begin
                            // Wait for DATA packets
                        end
                        TEST_SEND: begin
                            send_start_o = 1'b1;
                            state_d      = ST_SEND;
                        end
                        default: begin
                            report  = 1'b1;
                            rep_err = ERR_INVALID_TEST_NUM;
                            rep_len = len_t'(2);
                        end
                    endcase
                end else if (take_o && cmd_i == CMD_TEST_DATA) begin
                    if (rd_data_i != expected_i) begin
                        report  = 1'b1;
                        rep_err = ERR_INVALID_TEST_DATA;
                        rep_len = len_t'(3);
                    end else begin
                        advance_o = 1'b1;
                        // Loopback echoes the byte in its own packet
                        if (test_num == TEST_RECEIVE_SEND) begin
                            load_o     = 1'b1;
                            load_cmd_o = CMD_TEST_DATA;
                            load_b1_o  = rd_data_i;
                            state_d    = ST_ECHO;
                        end
                    end
                end
            end
            ST_ECHO: begin
                if (!busy_i) begin
                    state_d = ST_READ;
                end
            end
            ST_SEND: begin
                if (pat_take_i && pat_last_i) begin
                    report = 1'b1;
                end
            end
            ST_REPORT: begin
                if (!busy_i) begin
                    state_d = ST_HALT;
                end
            end
            default: state_d = ST_HALT;
        endcase

        if (report) begin
            load_o     = 1'b1;
            load_cmd_o = CMD_TEST_STOPPED;
            load_len_o = rep_len;
            load_b1_o  = rep_err;
            state_d    = ST_REPORT;
        end
    end

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state       <= ST_READ;
            test_num    <= '0;
            err_code    <= ERR_NONE;
            test_ok_o   <= 1'b0;
            test_fail_o <= 1'b0;
        end else begin
            state <= state_d;
            if (start_pld) begin
                test_num <= rd_data_i;
            end
            if (report) begin
                err_code <= rep_err;
            end
            // Status shows once the stop reply has drained
            if (start_hdr) begin
                test_ok_o   <= 1'b0;
                test_fail_o <= 1'b0;
            end else if (state == ST_REPORT && !busy_i) begin
                test_ok_o   <= (err_code == ERR_NONE);
                test_fail_o <= (err_code != ERR_NONE);
            end
        end
    end

endmodule

// ==== verilog/test_ctrl_top.sv ====
module test_ctrl_top #(
    parameter int unsigned PACKET_COUNT   = 1,
    parameter int unsigned PACKET_PAYLOAD = 63
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  rd_empty_i,
    input  test_proto_pkg::byte_t rd_data_i,
    input  logic                  wr_full_i,
    input  logic                  wr_afull_i,
    output logic                  rd_en_o,
    output logic                  wr_en_o,
    output test_proto_pkg::byte_t wr_data_o,
    output logic                  test_ok_o,
    output logic                  test_fail_o
);
    import test_proto_pkg::*;

    logic  take, is_header, clear, advance, send_start;
    logic  stream, load, busy, pat_take, pat_last;
    cmd_t  cmd, load_cmd;
    len_t  len, load_len;
    byte_t expected, pat_byte, load_b1, load_b2, load_b3;

    // ====================
    // Input side
    // ====================
    packet_parser u_parser (
        .clk(clk), .reset_i(reset_i), .take_i(take), .byte_i(rd_data_i),
        .is_header_o(is_header), .cmd_o(cmd), .len_o(len)
    );

    pattern_gen #(
        .PACKET_COUNT(PACKET_COUNT),
        .PACKET_PAYLOAD(PACKET_PAYLOAD)
    ) u_pattern (
        .clk(clk), .reset_i(reset_i), .clear_i(clear), .advance_i(advance),
        .send_start_i(send_start), .pat_take_i(pat_take),
        .expected_o(expected), .pat_byte_o(pat_byte), .pat_last_o(pat_last)
    );

    test_ctrl_fsm u_fsm (
        .clk(clk), .reset_i(reset_i), .rd_empty_i(rd_empty_i), .rd_data_i(rd_data_i),
        .is_header_i(is_header), .cmd_i(cmd), .len_i(len), .expected_i(expected),
        .pat_last_i(pat_last), .pat_take_i(pat_take), .busy_i(busy),
        .rd_en_o(rd_en_o), .take_o(take), .clear_o(clear), .advance_o(advance),
        .send_start_o(send_start), .stream_o(stream), .load_o(load),
        .load_cmd_o(load_cmd), .load_len_o(load_len),
        .load_b1_o(load_b1), .load_b2_o(load_b2), .load_b3_o(load_b3),
        .test_ok_o(test_ok_o), .test_fail_o(test_fail_o)
    );

    // Output side
    reply_writer u_writer (
        .clk(clk), .reset_i(reset_i), .load_i(load),
        .load_cmd_i(load_cmd), .load_len_i(load_len),
        .load_b1_i(load_b1), .load_b2_i(load_b2), .load_b3_i(load_b3),
        .stream_i(stream), .pat_byte_i(pat_byte),
        .wr_full_i(wr_full_i), .wr_afull_i(wr_afull_i),
        .busy_o(busy), .pat_take_o(pat_take), .wr_en_o(wr_en_o), .wr_data_o(wr_data_o)
    );

endmodule

// ==== test/tb_test_ctrl.sv ====
module tb_test_ctrl;
    import test_proto_pkg::*;

    localparam int PACKET_COUNT   = 2;
    localparam int PACKET_PAYLOAD = 5;
    localparam int TIMEOUT        = 600;

    logic   clk;
    logic   reset_i    = 1'b1;
    logic   rd_empty_i = 1'b1;
    byte_t  rd_data_i  = 8'h00;
    logic   wr_full_i  = 1'b0;
    logic   wr_afull_i = 1'b0;
    logic   rd_en_o;
    logic   wr_en_o;
    byte_t  wr_data_o;
    logic   test_ok_o;
    logic   test_fail_o;

    byte_t  stim_q[$];
    byte_t  in_q[$];
    byte_t  out_q[$];
    byte_t  exp_q[$];
    integer seed   = 32'h7f17;
    int     checks = 0;
    int     errors = 0;

    test_ctrl_top #(
        .PACKET_COUNT(PACKET_COUNT),
        .PACKET_PAYLOAD(PACKET_PAYLOAD)
    ) dut0 (
        .clk(clk), .reset_i(reset_i), .rd_empty_i(rd_empty_i), .rd_data_i(rd_data_i),
        .wr_full_i(wr_full_i), .wr_afull_i(wr_afull_i), .rd_en_o(rd_en_o),
        .wr_en_o(wr_en_o), .wr_data_o(wr_data_o),
        .test_ok_o(test_ok_o), .test_fail_o(test_fail_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // FIFO models
    // ====================
    // Input FIFO shows its head byte while not empty
    always @(posedge clk) begin
        if (!reset_i && rd_en_o && !rd_empty_i) begin
            void'(in_q.pop_front());
        end
        rd_empty_i <= (in_q.size() == 0);
        rd_data_i  <= (in_q.size() != 0) ? in_q[0] : 8'h00;
    end

    // Random back-pressure on the output FIFO
    always @(posedge clk) begin
        wr_full_i  <= ($random(seed) & 7) < 2;
        wr_afull_i <= ($random(seed) & 7) < 2;
    end

    always @(posedge clk) begin
        if (!reset_i && wr_en_o) begin
            out_q.push_back(wr_data_o);
        end
    end

    // ====================
    // Assertions
    // ====================
    // A write needs both flags low at the edge before it
    write_needs_space: assert property (@(posedge clk) disable iff (reset_i)
        wr_en_o |-> (!$past(wr_full_i) && !$past(wr_afull_i)))
    else begin
        errors++;
        $display("FAILED %0t: write while the output FIFO had no space", $time);
    end

    no_read_while_busy: assert property (@(posedge clk) disable iff (reset_i)
        !(rd_en_o && dut0.busy))
    else begin
        errors++;
        $display("FAILED %0t: rd_en_o high while a reply is pending", $time);
    end

    one_status: assert property (@(posedge clk) disable iff (reset_i)
        !(test_ok_o && test_fail_o))
    else begin
        errors++;
        $display("FAILED %0t: test_ok_o and test_fail_o both high", $time);
    end

    // ====================
    // Helpers
    // ====================
    function automatic byte_t header(input cmd_t cmd, input int len);
        return {cmd, len_t'(len)};
    endfunction

    function automatic void new_scenario();
        stim_q.delete();
        exp_q.delete();
    endfunction

    function automatic void start_test(input test_num_t num);
        stim_q.push_back(header(CMD_TEST_START, 1));
        stim_q.push_back(num);
    endfunction

    // Stop reply is header, error code, then up to two extra bytes
    function automatic void expect_stop(input err_code_t err, input int extra,
                                        input byte_t b2, input byte_t b3);
        exp_q.push_back(header(CMD_TEST_STOPPED, 1 + extra));
        exp_q.push_back(err);
        if (extra > 0) begin
            exp_q.push_back(b2);
        end
        if (extra > 1) begin
            exp_q.push_back(b3);
        end
    endfunction

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic compare_output(input string name);
        int i;
        checks++;
        assert (out_q.size() == exp_q.size()) else begin
            errors++;
            $display("FAILED %0t: %s wrote %0d bytes, expected %0d", $time, name,
                     out_q.size(), exp_q.size());
        end
        for (i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
            checks++;
            assert (out_q[i] == exp_q[i]) else begin
                errors++;
                $display("FAILED %0t: %s byte %0d is %h, expected %h", $time, name, i,
                         out_q[i], exp_q[i]);
            end
        end
    endtask

    // Reset, load the input FIFO, wait for a status output
    task automatic run_scenario(input string name, input logic exp_ok);
        int cycles;
        @(posedge clk);
        reset_i <= 1'b1;
        @(posedge clk);
        in_q = stim_q;
        out_q.delete();
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        cycles = 0;
        while (!(test_ok_o || test_fail_o) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!(test_ok_o || test_fail_o)) begin
            errors++;
            $display("Timeout: %s gave no test result within %0d cycles", name, TIMEOUT);
        end else begin
            checks++;
            assert (test_ok_o == exp_ok && test_fail_o == !exp_ok) else begin
                errors++;
                $display("FAILED %0t: %s status ok=%b fail=%b", $time, name,
                         test_ok_o, test_fail_o);
            end
            compare_output(name);
        end
    endtask

    // ====================
    // Scenarios
    // ====================
    initial begin
        int i;
        new_scenario();
        start_test(TEST_RECEIVE);
        stim_q.push_back(header(CMD_TEST_DATA, 10));
        for (i = 0; i < 10; i++) begin
            stim_q.push_back(byte_t'(i));
        end
        stim_q.push_back(header(CMD_TEST_STOP, 0));
        expect_stop(ERR_NONE, 0, 8'h00, 8'h00);
        run_scenario("receive", 1'b1);

        // Loopback echoes each byte in its own packet
        new_scenario();
        start_test(TEST_RECEIVE_SEND);
        stim_q.push_back(header(CMD_TEST_DATA, 4));
        for (i = 0; i < 4; i++) begin
            stim_q.push_back(byte_t'(i));
            exp_q.push_back(header(CMD_TEST_DATA, 1));
            exp_q.push_back(byte_t'(i));
        end
        stim_q.push_back(header(CMD_TEST_STOP, 0));
        expect_stop(ERR_NONE, 0, 8'h00, 8'h00);
        run_scenario("loopback", 1'b1);

        new_scenario();
        start_test(TEST_SEND);
        for (i = 0; i < PACKET_COUNT * PACKET_PAYLOAD; i++) begin
            if (i % PACKET_PAYLOAD == 0) begin
                exp_q.push_back(header(CMD_TEST_DATA, PACKET_PAYLOAD));
            end
            exp_q.push_back(byte_t'(i));
        end
        expect_stop(ERR_NONE, 0, 8'h00, 8'h00);
        run_scenario("send", 1'b1);

        // Third byte breaks the pattern where 2 is expected
        new_scenario();
        start_test(TEST_RECEIVE);
        stim_q.push_back(header(CMD_TEST_DATA, 4));
        stim_q.push_back(8'h00);
        stim_q.push_back(8'h01);
        stim_q.push_back(8'h07);
        stim_q.push_back(8'h03);
        expect_stop(ERR_INVALID_TEST_DATA, 2, 8'h07, 8'h02);
        run_scenario("data mismatch", 1'b0);

        new_scenario();
        stim_q.push_back(header(CMD_TEST_STOPPED, 0));
        expect_stop(ERR_INVALID_CMD, 0, 8'h00, 8'h00);
        run_scenario("stopped header", 1'b0);

        new_scenario();
        stim_q.push_back(header(CMD_TEST_START, 2));
        stim_q.push_back(TEST_RECEIVE);
        stim_q.push_back(8'h00);
        expect_stop(ERR_INVALID_START_PAYLOAD, 0, 8'h00, 8'h00);
        run_scenario("start length", 1'b0);

        new_scenario();
        start_test(8'd9);
        expect_stop(ERR_INVALID_TEST_NUM, 1, 8'd9, 8'h00);
        run_scenario("test number", 1'b0);

        new_scenario();
        start_test(TEST_RECEIVE);
        stim_q.push_back(header(CMD_TEST_STOP, 1));
        stim_q.push_back(8'h00);
        expect_stop(ERR_INVALID_STOP_PAYLOAD, 0, 8'h00, 8'h00);
        run_scenario("stop length", 1'b0);

        finish_run();
    end

endmodule

// ==== flist.f ====
verilog/test_proto_pkg.sv
verilog/test_ctrl_pkg.sv
verilog/packet_parser.sv
verilog/pattern_gen.sv
verilog/reply_writer.sv
verilog/test_ctrl_fsm.sv
verilog/test_ctrl_top.sv
test/tb_test_ctrl.sv

// ==== Bender.yml ====
package:
  name: test_ctrl

sources:
  - verilog/test_proto_pkg.sv
  - verilog/test_ctrl_pkg.sv
  - verilog/packet_parser.sv
  - verilog/pattern_gen.sv
  - verilog/reply_writer.sv
  - verilog/test_ctrl_fsm.sv
  - verilog/test_ctrl_top.sv
  - target: test
    files:
      - test/tb_test_ctrl.sv
